//--- vlog.f
decoder_pkg.sv
opcode_fetch.sv
instr_pipe.sv
opword_issue.sv
opcode_decoder.sv
opcode_decoder_properties.sv
tb_opcode_decoder.sv

//--- Makefile
SRCS := $(wildcard *.sv)

obj_dir/Vtb_opcode_decoder: $(SRCS) vlog.f
	verilator --binary --timing --assert --top-module tb_opcode_decoder -f vlog.f

run: obj_dir/Vtb_opcode_decoder
	./obj_dir/Vtb_opcode_decoder

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- tb_opcode_decoder.sv
// Testbench for the opcode decoder.
// Random opcode memory with bus faults, random execution unit requests and
// random flushes, checked against an instruction stream model.

`default_nettype none

module tb_opcode_decoder;

    localparam int ADR_W           = decoder_pkg::DEFAULT_ADR_W;
    localparam int PERIOD          = 8;
    localparam int N_INSTR         = 400;
    localparam int WORDS_PER_INSTR = 5;  // Three base words, two extension words.
    localparam int CYC_PER_WORD    = 16; // Bus latency, request gaps and flushes.
    localparam int TIMEOUT         = N_INSTR * WORDS_PER_INSTR * CYC_PER_WORD * PERIOD;

    logic                   CLK = 1'b0;
    logic                   rst;
    logic                   opcode_rd;
    logic                   opcode_rdy;
    logic                   opcode_valid;
    decoder_pkg::word_t     opcode_data;
    logic [ADR_W-1:0]       fetch_adr;
    logic                   ipipe_flush;
    logic [ADR_W-1:0]       flush_adr;
    logic                   ow_req;
    logic                   ew_req;
    logic                   ow_ack;
    logic                   ew_ack;
    decoder_pkg::op_class_t op;
    decoder_pkg::trap_t     trap_code;
    decoder_pkg::word_t     biw_0;
    decoder_pkg::word_t     biw_1;
    decoder_pkg::word_t     biw_2;
    decoder_pkg::word_t     ext_word;
    logic                   ow_valid;
    logic                   fc;
    logic                   fb;

    decoder_pkg::word_t mem [2**ADR_W];    // Opcode memory, word addressed.
    logic               faulty [2**ADR_W]; // Words answered with opcode_valid low.
    integer             seed     = 86868;
    integer             bus_seed = 86868 + 1; // Own sequence for the memory model.
    logic [ADR_W-1:0]   rd_idx;               // Next word the model expects.

    opcode_decoder #(.ADR_W(ADR_W)) UUT (.*);

    always #(PERIOD / 2) CLK = !CLK;

    // ==================================================
    // Helpers.
    // ==================================================
    function automatic int rand_below(inout integer s, input int n);
        return int'({$random(s)} % n);
    endfunction

    // Random word, biased toward the decoded classes.
    function automatic decoder_pkg::word_t random_word();
        decoder_pkg::word_t w;
        int                 k;
        w = decoder_pkg::word_t'($random(seed));
        case (rand_below(seed, 8))
            0: w[15:12] = 4'h7; // MOVEQ.
            1: begin
                w[15:12] = 4'h6; // Bcc.
                case (rand_below(seed, 3))
                    0:       w[7:0] = 8'h00;
                    1:       w[7:0] = 8'hFF;
                    default: ;
                endcase
            end
            2, 3: begin
                k        = rand_below(seed, 6);
                w[15:12] = 4'h0;
                w[8]     = 1'b0;
                w[11:9]  = 3'(k < 4 ? k : k + 1); // Skips 4 and 7.
                w[7:6]   = 2'(rand_below(seed, 3));
            end
            4: w[15:12] = 4'hA;
            5: w[15:12] = 4'hF;
            default: ; // Anything at all.
        endcase
        return w;
    endfunction

    // Expected class, trap and length in words of an opcode word.
    function automatic void decode_model(input decoder_pkg::word_t w,
                                         output decoder_pkg::op_class_t opc,
                                         output decoder_pkg::trap_t trap,
                                         output int len);
        opc  = decoder_pkg::OPC_OTHER;
        trap = decoder_pkg::TRAP_NONE;
        len  = 1;
        if (w[15:12] == 4'h7) begin
            opc = decoder_pkg::OPC_MOVEQ;
        end else if (w[15:12] == 4'h6) begin
            opc = decoder_pkg::OPC_BCC;
            if (w[7:0] == 8'h00) begin
                len = 2; // Word displacement.
            end else if (w[7:0] == 8'hFF) begin
                len = 3; // Long displacement.
            end
        end else if (w[15:12] == 4'h0 && !w[8] && w[11:9] != 3'd4 && w[11:9] != 3'd7) begin
            opc = decoder_pkg::OPC_IMM;
            len = (w[7:6] == 2'b10) ? 3 : 2;
        end else if (w[15:12] == 4'hA) begin
            opc  = decoder_pkg::OPC_LINE_A;
            trap = decoder_pkg::TRAP_1010;
        end else if (w[15:12] == 4'hF) begin
            opc  = decoder_pkg::OPC_LINE_F;
            trap = decoder_pkg::TRAP_1111;
        end
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch.");
        end
    endtask

    task automatic idle_gap();
        repeat (rand_below(seed, 4)) begin
            @(posedge CLK);
            #1;
        end
    endtask

    // ==================================================
    // Execution unit side.
    // ==================================================
    // Flush to a random address, preferably while a read is in flight.
    task automatic flush_pipe();
        int tries;
        tries = 0;
        while (!opcode_rd && tries < 4) begin
            @(posedge CLK);
            #1;
            tries++;
        end
        flush_adr   = ADR_W'(rand_below(seed, 2**ADR_W));
        ipipe_flush = 1'b1;
        @(posedge CLK);
        #1;
        ipipe_flush = 1'b0;
        rd_idx      = flush_adr; // Stream restarts here.
    endtask

    task automatic issue_instruction();
        decoder_pkg::op_class_t exp_op;
        decoder_pkg::trap_t     exp_trap;
        int                     len;
        logic                   f_d;
        logic                   f_c;
        logic                   f_b;
        decode_model(mem[rd_idx], exp_op, exp_trap, len);
        f_d = faulty[rd_idx];
        f_c = len > 1 && faulty[rd_idx + ADR_W'(1)];
        f_b = len > 2 && faulty[rd_idx + ADR_W'(2)];
        idle_gap();
        ow_req = 1'b1;
        do begin
            @(posedge CLK);
            #1;
        end while (!ow_ack);
        ow_req = 1'b0; // Dropped in the acknowledge cycle.
        check_equal("biw_0", 32'(biw_0), 32'(mem[rd_idx]));
        check_equal("op", 32'(op), 32'(exp_op));
        check_equal("trap_code", 32'(trap_code), 32'(exp_trap));
        if (len > 1) begin
            check_equal("biw_1", 32'(biw_1), 32'(mem[rd_idx + ADR_W'(1)]));
        end
        if (len > 2) begin
            check_equal("biw_2", 32'(biw_2), 32'(mem[rd_idx + ADR_W'(2)]));
        end
        check_equal("ow_valid", 32'(ow_valid), 32'(!(f_d || f_c || f_b)));
        check_equal("fc", 32'(fc), 32'(f_c));
        check_equal("fb", 32'(fb), 32'(f_b));
        rd_idx = rd_idx + ADR_W'(len);
    endtask

    task automatic fetch_extension();
        idle_gap();
        ew_req = 1'b1;
        do begin
            @(posedge CLK);
            #1;
        end while (!ew_ack);
        ew_req = 1'b0;
        check_equal("ext_word", 32'(ext_word), 32'(mem[rd_idx]));
        rd_idx = rd_idx + ADR_W'(1);
    endtask

    // ==================================================
    // Memory model, answers a read after 0 to 3 idle cycles.
    // ==================================================
    initial begin : bus_model
        logic [ADR_W-1:0] bus_adr;
        opcode_rdy   = 1'b0;
        opcode_valid = 1'b1;
        opcode_data  = '0;
        bus_adr      = '0;
        forever begin
            @(posedge CLK);
            #1;
            opcode_rdy = 1'b0;
            if (opcode_rd && !rst) begin
                bus_adr = fetch_adr; // Address latched as the read starts.
                repeat (rand_below(bus_seed, 4)) begin
                    @(posedge CLK);
                end
                #1;
                opcode_rdy   = 1'b1;
                opcode_data  = mem[bus_adr];
                opcode_valid = !faulty[bus_adr];
            end
        end
    end

    initial begin : stimulus
        logic [ADR_W-1:0] adr;
        rst         = 1'b1;
        ipipe_flush = 1'b0;
        flush_adr   = '0;
        ow_req      = 1'b0;
        ew_req      = 1'b0;
        adr         = '0;
        repeat (2**ADR_W) begin
            mem[adr]    = random_word();
            faulty[adr] = (rand_below(seed, 20) == 0); // About 5 percent.
            adr++;
        end
        repeat (2) @(posedge CLK);
        #1;
        rst = 1'b0;
        check_equal("ow_ack", 32'(ow_ack), 32'd0);
        check_equal("ew_ack", 32'(ew_ack), 32'd0);
        check_equal("ow_valid", 32'(ow_valid), 32'd0);
        check_equal("trap_code", 32'(trap_code), 32'(decoder_pkg::TRAP_NONE));
        rd_idx = '0; // Fetch starts at word 0.
        for (int n = 0; n < N_INSTR; n++) begin
            if (rand_below(seed, 12) == 0) begin
                flush_pipe();
            end
            issue_instruction();
            repeat (rand_below(seed, 3)) begin
                if (rand_below(seed, 2) == 0) begin
                    fetch_extension();
                end
            end
        end
        repeat (4) @(posedge CLK);
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout at %0t: the DUT stopped acknowledging requests.", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired.");
    end

endmodule

`default_nettype wire

//--- opcode_decoder_properties.sv
// Handshake and pipe checks for the opcode decoder.
// Bound into the top level, where the pipe strobes meet the bus ports.

`default_nettype none

module opcode_decoder_properties (
    input logic              CLK,
    input logic              rst,
    input logic              ow_ack,
    input logic              ew_ack,
    input decoder_pkg::ptr_t ptr,
    input logic              word_taken,
    input logic              ow_take,
    input logic              ew_take,
    input logic              opcode_rd,
    input logic              opcode_rdy
);

    // The two acknowledges share one execution unit port.
    acks_exclusive: assert property (@(posedge CLK) disable iff (rst)
        !(ow_ack && ew_ack))
        else $error("ow_ack and ew_ack high in the same cycle.");

    // A full pipe stores a word only while one leaves, so ptr stays within 3.
    no_overfill: assert property (@(posedge CLK) disable iff (rst)
        (ptr == 2'd3 && word_taken) |-> (ow_take || ew_take))
        else $error("Word stored into a full pipe.");

    // Read strobe stays up until the bus answers.
    rd_held: assert property (@(posedge CLK) disable iff (rst)
        (opcode_rd && !opcode_rdy) |=> opcode_rd)
        else $error("opcode_rd fell without opcode_rdy.");

endmodule

bind opcode_decoder opcode_decoder_properties u_props (
    .CLK       (CLK),
    .rst       (rst),
    .ow_ack    (ow_ack),
    .ew_ack    (ew_ack),
    .ptr       (ptr),
    .word_taken(word_taken),
    .ow_take   (ow_take),
    .ew_take   (ew_take),
    .opcode_rd (opcode_rd),
    .opcode_rdy(opcode_rdy)
);

`default_nettype wire

//--- opcode_decoder.sv
// Opcode decoder, first CPU pipeline stage.
// Prefetch, three word instruction pipe and issue stage.

`default_nettype none

module opcode_decoder #(
    parameter int ADR_W = decoder_pkg::DEFAULT_ADR_W
) (
    input  logic                   CLK,
    input  logic                   rst,
    // Opcode bus.
    output logic                   opcode_rd,
    input  logic                   opcode_rdy,
    input  logic                   opcode_valid,
    input  decoder_pkg::word_t     opcode_data,
    output logic [ADR_W-1:0]       fetch_adr,
    // Pipe flush.
    input  logic                   ipipe_flush,
    input  logic [ADR_W-1:0]       flush_adr,
    // Execution unit.
    input  logic                   ow_req,
    input  logic                   ew_req,
    output logic                   ow_ack,
    output logic                   ew_ack,
    output decoder_pkg::op_class_t op,
    output decoder_pkg::trap_t     trap_code,
    output decoder_pkg::word_t     biw_0,
    output decoder_pkg::word_t     biw_1,
    output decoder_pkg::word_t     biw_2,
    output decoder_pkg::word_t     ext_word,
    output logic                   ow_valid,
    output logic                   fc,
    output logic                   fb
);

    logic                    word_in_valid; // Fetch to pipe.
    logic                    word_taken;
    decoder_pkg::ptr_t       ptr;
    logic                    ow_take;       // Pipe to issue.
    logic                    ew_take;
    decoder_pkg::word_t      ipipe_d;
    decoder_pkg::word_t      ipipe_c;
    decoder_pkg::word_t      ipipe_b;
    logic                    fault_d;
    logic                    fault_c;
    logic                    fault_b;
    decoder_pkg::instr_lvl_t instr_lvl;     // Issue back to pipe.

    opcode_fetch #(.ADR_W(ADR_W)) u_fetch (.*);

    instr_pipe u_pipe (.*);

    opword_issue u_issue (.*);

endmodule

`default_nettype wire

//--- opword_issue.sv
// Operation word issue stage.
// Decodes pipe slot D into an operation class, a trap and a length, and
// registers the base words or one extension word for the execution unit
// together with the acknowledge and the fault flags.

`default_nettype none

module opword_issue (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    ipipe_flush,
    input  decoder_pkg::word_t      ipipe_d,
    input  decoder_pkg::word_t      ipipe_c,
    input  decoder_pkg::word_t      ipipe_b,
    input  logic                    fault_d,
    input  logic                    fault_c,
    input  logic                    fault_b,
    input  logic                    ow_take,   // Base words leave the pipe.
    input  logic                    ew_take,   // One extension word leaves.
    output decoder_pkg::instr_lvl_t instr_lvl,
    output decoder_pkg::op_class_t  op,
    output decoder_pkg::trap_t      trap_code,
    output decoder_pkg::word_t      biw_0,
    output decoder_pkg::word_t      biw_1,
    output decoder_pkg::word_t      biw_2,
    output decoder_pkg::word_t      ext_word,
    output logic                    ow_ack,
    output logic                    ew_ack,
    output logic                    ow_valid,
    output logic                    fc,
    output logic                    fb
);

    decoder_pkg::op_class_t op_i;
    decoder_pkg::trap_t     trap_i;
    logic                   imm_group; // Line 0 immediate arithmetic.
    logic                   uses_c;
    logic                   uses_b;

    // ==================================================
    // Decode of slot D.
    // ==================================================
    // Bit 8 set is the bit ops, 4 and 7 in bits 11 to 9 are BTST and MOVES.
    assign imm_group = ipipe_d[15:12] == 4'h0 && !ipipe_d[8] &&
                       ipipe_d[11:9] != 3'd4 && ipipe_d[11:9] != 3'd7;

    always_comb begin : decode
        op_i      = decoder_pkg::OPC_OTHER;
        trap_i    = decoder_pkg::TRAP_NONE;
        instr_lvl = decoder_pkg::LVL_D;
        case (ipipe_d[15:12])
            4'h7: op_i = decoder_pkg::OPC_MOVEQ;
            4'h6: begin
                op_i = decoder_pkg::OPC_BCC;
                if (ipipe_d[7:0] == 8'h00) begin
                    instr_lvl = decoder_pkg::LVL_C; // 16 bit displacement.
                end else if (ipipe_d[7:0] == 8'hFF) begin
                    instr_lvl = decoder_pkg::LVL_B; // 32 bit displacement.
                end
            end
            4'h0: begin
                if (imm_group) begin
                    op_i = decoder_pkg::OPC_IMM;
                    if (ipipe_d[7:6] == 2'b10) begin
                        instr_lvl = decoder_pkg::LVL_B; // Long immediate.
                    end else begin
                        instr_lvl = decoder_pkg::LVL_C;
                    end
                end
            end
            4'hA: begin
                op_i   = decoder_pkg::OPC_LINE_A;
                trap_i = decoder_pkg::TRAP_1010;
            end
            4'hF: begin
                op_i   = decoder_pkg::OPC_LINE_F;
                trap_i = decoder_pkg::TRAP_1111;
            end
            default: ;
        endcase
    end

    assign uses_c = instr_lvl != decoder_pkg::LVL_D;
    assign uses_b = instr_lvl == decoder_pkg::LVL_B;

    // ==================================================
    // Handshake and fault flags.
    // ==================================================
    always_ff @(posedge CLK) begin
        if (rst || ipipe_flush) begin
            ow_ack    <= 1'b0;
            ew_ack    <= 1'b0;
            ow_valid  <= 1'b0;
            fc        <= 1'b0;
            fb        <= 1'b0;
            trap_code <= decoder_pkg::TRAP_NONE;
        end else begin
            ow_ack <= ow_take; // One cycle pulse per take.
            ew_ack <= ew_take;
            if (ow_take) begin
                ow_valid  <= !(fault_d || (uses_c && fault_c) || (uses_b && fault_b));
                fc        <= uses_c && fault_c;
                fb        <= uses_b && fault_b;
                trap_code <= trap_i;
            end
        end
    end

    // All three base words go out, the execution unit uses what it needs.
    always_ff @(posedge CLK) begin
        if (ow_take) begin
            op    <= op_i;
            biw_0 <= ipipe_d;
            biw_1 <= ipipe_c;
            biw_2 <= ipipe_b;
        end
        if (ew_take) begin
            ext_word <= ipipe_d; // Extension word always sits in D.
        end
    end

endmodule

`default_nettype wire

//--- instr_pipe.sv
// Instruction pipe.
// Three word buffer, slots D, C and B, each with a fault bit. Fills from
// the opcode bus, shifts out the words that the issue stage consumes
// and decides when a request can be served.

`default_nettype none

module instr_pipe (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    ipipe_flush,
    input  logic                    word_in_valid, // Opcode word arriving.
    input  logic                    opcode_valid,  // Low on a bus fault.
    input  decoder_pkg::word_t      opcode_data,
    input  logic                    ow_req,
    input  logic                    ew_req,
    input  decoder_pkg::instr_lvl_t instr_lvl,     // Length of the word in D.
    output logic                    word_taken,
    output logic                    ow_take,
    output logic                    ew_take,
    output decoder_pkg::ptr_t       ptr,
    output decoder_pkg::word_t      ipipe_d,
    output decoder_pkg::word_t      ipipe_c,
    output decoder_pkg::word_t      ipipe_b,
    output logic                    fault_d,
    output logic                    fault_c,
    output logic                    fault_b
);

    decoder_pkg::word_t words [3];      // Index 0 is D, 1 is C, 2 is B.
    logic               faults [3];
    decoder_pkg::word_t words_nxt [3];
    logic               faults_nxt [3];
    decoder_pkg::ptr_t  used;           // Words shifted out this cycle.
    decoder_pkg::ptr_t  rest;           // Words left behind.
    logic               ow_rdy;

    // ==================================================
    // Readiness.
    // ==================================================
    // D and C are both needed before a length can be trusted.
    always_comb begin
        if (instr_lvl == decoder_pkg::LVL_B) begin
            ow_rdy = (ptr == 2'd3);
        end else begin
            ow_rdy = (ptr >= 2'd2);
        end
    end

    assign ow_take = ow_req && ow_rdy && !ipipe_flush;
    assign ew_take = ew_req && ptr != 2'd0 && !ipipe_flush; // One word is enough.

    always_comb begin
        used = 2'd0;
        if (ow_take) begin
            case (instr_lvl)
                decoder_pkg::LVL_C: used = 2'd2;
                decoder_pkg::LVL_B: used = 2'd3;
                default:            used = 2'd1;
            endcase
        end else if (ew_take) begin
            used = 2'd1;
        end
    end

    assign rest = ptr - used;
    // A full pipe that is not drained drops the word, it is read again.
    assign word_taken = word_in_valid && !ipipe_flush && rest != 2'd3;

    // ==================================================
    // Shift and append.
    // ==================================================
    always_comb begin : shift
        logic [2:0] src;
        for (int i = 0; i < 3; i++) begin
            src = 3'(i) + {1'b0, used};
            if (src < 3'd3) begin
                words_nxt[i]  = words[src[1:0]];
                faults_nxt[i] = faults[src[1:0]];
            end else begin
                words_nxt[i]  = words[i]; // Beyond ptr, contents are stale.
                faults_nxt[i] = faults[i];
            end
        end
        if (word_taken) begin
            words_nxt[rest]  = opcode_data;   // Lands behind the remaining words.
            faults_nxt[rest] = !opcode_valid;
        end
    end

    always_ff @(posedge CLK) begin
        words  <= words_nxt;
        faults <= faults_nxt;
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            ptr <= '0;
        end else if (ipipe_flush) begin
            ptr <= '0; // Pipe abandoned.
        end else begin
            ptr <= rest + {1'b0, word_taken};
        end
    end

    assign ipipe_d = words[0];
    assign ipipe_c = words[1];
    assign ipipe_b = words[2];
    assign fault_d = faults[0];
    assign fault_c = faults[1];
    assign fault_b = faults[2];

endmodule

`default_nettype wire

//--- opcode_fetch.sv
// Opcode prefetch.
// Issues opcode reads while the instruction pipe has room, throws away
// the answer of a read that a flush has cut off, and keeps the word
// address of the next opcode.

`default_nettype none

module opcode_fetch #(
    parameter int ADR_W = 16
) (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    ipipe_flush,
    input  logic [ADR_W-1:0]        flush_adr,   // New fetch address on a flush.
    input  decoder_pkg::ptr_t       ptr,
    input  logic                    word_taken,  // Pipe stored the word.
    input  logic                    opcode_rdy,
    output logic                    opcode_rd,
    output logic                    word_in_valid,
    output logic [ADR_W-1:0]        fetch_adr
);

    logic discard; // Pending read belongs to the flushed stream.

    // Read strobe. Held as a level until the bus answers.
    always_ff @(posedge CLK) begin
        if (rst) begin
            opcode_rd <= 1'b0;
        end else if (opcode_rdy) begin
            opcode_rd <= 1'b0; // Cycle done.
        end else if (!opcode_rd && ptr != 2'd3) begin
            opcode_rd <= 1'b1; // Room left in the pipe.
        end
    end

    // A flush can not abort the bus cycle, so its answer is dismissed.
    always_ff @(posedge CLK) begin
        if (rst) begin
            discard <= 1'b0;
        end else if (ipipe_flush && opcode_rd && !opcode_rdy) begin
            discard <= 1'b1;
        end else if (opcode_rdy) begin
            discard <= 1'b0; // Stale word has gone by.
        end
    end

    assign word_in_valid = opcode_rdy && !discard;

    // Word address. Only moves when the pipe keeps the word.
    always_ff @(posedge CLK) begin
        if (rst) begin
            fetch_adr <= '0;
        end else if (ipipe_flush) begin
            fetch_adr <= flush_adr;
        end else if (word_taken) begin
            fetch_adr <= fetch_adr + ADR_W'(1);
        end
    end

endmodule

`default_nettype wire

//--- decoder_pkg.sv
// Opcode decoder package.
// Word and pointer widths, the decode enums and the trap codes shared
// by the prefetch, the instruction pipe and the issue stage.

`default_nettype none

package decoder_pkg;

    // ==================================================
    // Widths.
    // ==================================================
    localparam int WORD_W        = 16; // One instruction word.
    localparam int DEFAULT_ADR_W = 16; // Fetch address, counted in words.

    typedef logic [WORD_W-1:0] word_t; // Opcode, pipe slot, BIW and extension word.
    typedef logic [1:0]        ptr_t;  // Valid pipe words, 0 to 3.

    // ==================================================
    // Decode results.
    // ==================================================
    // Instruction length, named after the last pipe slot it uses.
    typedef enum logic [1:0] {
        LVL_D = 2'd0, // One word.
        LVL_C = 2'd1, // Two words.
        LVL_B = 2'd2  // Three words.
    } instr_lvl_t;

    typedef enum logic [2:0] {
        OPC_MOVEQ  = 3'd0, // Line 7.
        OPC_BCC    = 3'd1, // Line 6, any displacement size.
        OPC_IMM    = 3'd2, // ORI, ANDI, SUBI, ADDI, EORI, CMPI.
        OPC_LINE_A = 3'd3, // Unimplemented, traps.
        OPC_LINE_F = 3'd4, // Unimplemented, traps.
        OPC_OTHER  = 3'd5  // Treated as a one word operation.
    } op_class_t;

    // Traps raised by the decoder.
    typedef enum logic [1:0] {
        TRAP_NONE = 2'd0,
        TRAP_1010 = 2'd1, // Line A emulator.
        TRAP_1111 = 2'd2  // Line F emulator.
    } trap_t;

endpackage

`default_nettype wire
